// ==== rtl/req_eval_defines.svh ====
`ifndef REQ_EVAL_DEFINES_SVH
`define REQ_EVAL_DEFINES_SVH

// router output ports seen by the evaluator
`define PORT_NUM 8

// credit count per port, all ones means no credit info or masked
`define CREDIT_W 5

// request count, holds 0 to 15
`define COUNT_W 4

// binary port index
`define INDEX_W 3

// counter input after zero padding of the request vector
`define PC_IN_W 15

`endif

// ==== rtl/req_eval_pkg.sv ====
`include "req_eval_defines.svh"

package req_eval_pkg;

    // one bit per output port, requests and one-hot winner
    typedef logic [`PORT_NUM-1:0] port_vec_t;

    // single credit count
    typedef logic [`CREDIT_W-1:0] credit_t;

    // credits of all ports, port 0 in the lowest slice
    typedef credit_t [`PORT_NUM-1:0] credit_arr_t;

    // number of set request bits
    typedef logic [`COUNT_W-1:0] count_t;

    // binary port number
    typedef logic [`INDEX_W-1:0] index_t;

endpackage

// ==== rtl/carry_sum_cell.sv ====
`timescale 1ns/1ps

module carry_sum_cell (
    input  logic [6:0] in,
    output logic [2:0] abc,
    output logic       s
);

    // ones in the low group of four
    logic [2:0] grp4_cnt;
    // ones in the high group of three
    logic [1:0] grp3_cnt;
    logic       carry_a;
    logic       carry_b;
    logic       carry_c;

    // small adders, each bit widened before the sum
    assign grp4_cnt = {2'b00, in[0]} + {2'b00, in[1]} + {2'b00, in[2]} + {2'b00, in[3]};
    assign grp3_cnt = {1'b0, in[4]} + {1'b0, in[5]} + {1'b0, in[6]};

    // parity of the whole input
    assign s = grp4_cnt[0] ^ grp3_cnt[0];

    // pair found inside the group of four
    assign carry_a = (grp4_cnt > 3'd1);

    // pair found inside the group of three
    assign carry_b = (grp3_cnt > 2'd1);

    // second pair of a full group of four,
    // or two odd leftovers that combine across the groups
    assign carry_c = (grp4_cnt == 3'd4) | (grp4_cnt[0] & grp3_cnt[0]);

    // ones in input = s + 2 * (ones in abc)
    assign abc = {carry_a, carry_b, carry_c};

endmodule

// ==== rtl/par_count_7.sv ====
`timescale 1ns/1ps

module par_count_7 (
    input  logic [6:0] in,
    output logic [2:0] out
);

    logic [2:0] cs_abc;
    logic       cs_s;

    // one reduction cell does the whole job
    carry_sum_cell cs_i (
        .in  (in),
        .abc (cs_abc),
        .s   (cs_s)
    );

    // weight one comes straight from the parity
    assign out[0] = cs_s;

    // carries all carry weight two, so just add them
    assign out[2:1] = {1'b0, cs_abc[2]} + {1'b0, cs_abc[1]} + {1'b0, cs_abc[0]};

endmodule

// ==== rtl/par_count_15.sv ====
`timescale 1ns/1ps
`include "req_eval_defines.svh"

module par_count_15 (
    input  logic [`PC_IN_W-1:0]  in,
    output req_eval_pkg::count_t out
);

    logic [2:0] abc_lo;
    logic [2:0] abc_hi;
    logic       s_lo;
    logic       s_hi;
    // leftover bit plus both parities, two bit sum
    logic [1:0] par_sum;
    logic [2:0] upper_cnt;

    // first 7 inputs
    carry_sum_cell cs_lo_i (
        .in  (in[6:0]),
        .abc (abc_lo),
        .s   (s_lo)
    );

    // next 7 inputs
    carry_sum_cell cs_hi_i (
        .in  (in[13:7]),
        .abc (abc_hi),
        .s   (s_hi)
    );

    // bit 14 has no cell, fold it in with the parities
    assign par_sum = {1'b0, in[14]} + {1'b0, s_lo} + {1'b0, s_hi};

    // six carries plus the extra carry, all weight two
    par_count_7 pc7_i (
        .in  ({abc_lo, abc_hi, par_sum[1]}),
        .out (upper_cnt)
    );

    assign out = {upper_cnt, par_sum[0]};

endmodule

// ==== rtl/req_count_stage.sv ====
`timescale 1ns/1ps
`include "req_eval_defines.svh"

module req_count_stage (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    in_valid,
    input  req_eval_pkg::port_vec_t req,
    output logic                    cnt_valid,
    output req_eval_pkg::count_t    cnt,
    output logic                    cnt_single
);

    import req_eval_pkg::*;

    // requests widened to the counter input
    logic [`PC_IN_W-1:0] pc_in;
    count_t              req_cnt;
    logic                single_req;

    // upper counter inputs tied low
    assign pc_in = {{(`PC_IN_W - `PORT_NUM){1'b0}}, req};

    par_count_15 pc15_i (
        .in  (pc_in),
        .out (req_cnt)
    );

    // zero or one request
    assign single_req = (req_cnt <= count_t'(1));

    // valid follows the strobe every cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt_valid <= 1'b0;
        end else begin
            cnt_valid <= in_valid;
        end
    end

    // results only load on a strobe, otherwise hold
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt        <= '0;
            cnt_single <= 1'b0;
        end else if (in_valid) begin
            cnt        <= req_cnt;
            cnt_single <= single_req;
        end
    end

endmodule

// ==== rtl/min_search_stage.sv ====
`timescale 1ns/1ps
`include "req_eval_defines.svh"

module min_search_stage (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      in_valid,
    input  req_eval_pkg::port_vec_t   req,
    input  req_eval_pkg::credit_arr_t credits,
    output logic                      min_valid,
    output req_eval_pkg::port_vec_t   min_onehot,
    output req_eval_pkg::credit_arr_t min_credits
);

    import req_eval_pkg::*;

    credit_arr_t masked;
    // row i holds the comparisons of port i against every port
    logic [`PORT_NUM-1:0][`PORT_NUM-1:0] cmp_mat;
    port_vec_t                           winner;

    genvar i, j;

    generate
        for (i = 0; i < `PORT_NUM; i++) begin : g_row
            // idle ports get the largest credit so they lose
            assign masked[i] = req[i] ? credits[i] : '1;

            for (j = 0; j < `PORT_NUM; j++) begin : g_col
                if (j > i) begin : g_upper
                    // ties with a later port go to port i
                    assign cmp_mat[i][j] = (masked[i] <= masked[j]);
                end else if (j < i) begin : g_lower
                    // mirrored compare negated
                    // so port i must be strictly below an earlier port
                    assign cmp_mat[i][j] = ~(masked[j] <= masked[i]);
                end else begin : g_diag
                    assign cmp_mat[i][j] = 1'b1;
                end
            end

            // port wins only if every compare holds
            assign winner[i] = &cmp_mat[i];
        end
    endgenerate

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            min_valid <= 1'b0;
        end else begin
            min_valid <= in_valid;
        end
    end

    // winner and masked credits load together
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            min_onehot  <= '0;
            min_credits <= '0;
        end else if (in_valid) begin
            min_onehot  <= winner;
            min_credits <= masked;
        end
    end

endmodule

// ==== rtl/one_hot_mux.sv ====
`timescale 1ns/1ps
`include "req_eval_defines.svh"

module one_hot_mux #(
    parameter type payload_t = logic
) (
    input  req_eval_pkg::port_vec_t    sel,
    input  payload_t [`PORT_NUM-1:0]   mux_in,
    output payload_t                   mux_out
);

    // per entry, zero unless its select bit is set
    payload_t [`PORT_NUM-1:0] masked;

    genvar i;

    generate
        for (i = 0; i < `PORT_NUM; i++) begin : g_mask
            // select bit replicated across the payload
            assign masked[i] = payload_t'(mux_in[i] & {$bits(payload_t){sel[i]}});
        end
    endgenerate

    // wide OR over all masked entries
    always_comb begin
        mux_out = '0;
        for (int k = 0; k < `PORT_NUM; k++) begin
            mux_out = payload_t'(mux_out | masked[k]);
        end
    end

    // with a one-hot select exactly one entry passes,
    // with zero select the output is all zeros

endmodule

// ==== rtl/port_pick_stage.sv ====
`timescale 1ns/1ps
`include "req_eval_defines.svh"

module port_pick_stage (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      min_valid,
    input  req_eval_pkg::port_vec_t   min_onehot,
    input  req_eval_pkg::credit_arr_t min_credits,
    input  req_eval_pkg::count_t      cnt,
    input  logic                      cnt_single,
    output logic                      out_valid,
    output req_eval_pkg::count_t      req_count,
    output req_eval_pkg::index_t      min_port,
    output req_eval_pkg::credit_t     min_credit,
    output logic                      req_single
);

    import req_eval_pkg::*;

    // constant table, entry i holds the number i
    index_t [`PORT_NUM-1:0] port_tab;
    index_t                 pick_idx;
    credit_t                pick_credit;

    genvar i;

    generate
        for (i = 0; i < `PORT_NUM; i++) begin : g_tab
            assign port_tab[i] = index_t'(i);
        end
    endgenerate

    // one-hot to binary
    one_hot_mux #(
        .payload_t (index_t)
    ) idx_mux_i (
        .sel     (min_onehot),
        .mux_in  (port_tab),
        .mux_out (pick_idx)
    );

    // credit of the winning port
    one_hot_mux #(
        .payload_t (credit_t)
    ) credit_mux_i (
        .sel     (min_onehot),
        .mux_in  (min_credits),
        .mux_out (pick_credit)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= min_valid;
        end
    end

    // count branch results ride along with the min strobe
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_count  <= '0;
            req_single <= 1'b0;
            min_port   <= '0;
            min_credit <= '0;
        end else if (min_valid) begin
            req_count  <= cnt;
            req_single <= cnt_single;
            min_port   <= pick_idx;
            min_credit <= pick_credit;
        end
    end

endmodule

// ==== rtl/req_eval_top.sv ====
`timescale 1ns/1ps

module req_eval_top (
    input  logic                      clk,
    input  logic                      arst_n,
    input  logic                      in_valid,
    input  req_eval_pkg::port_vec_t   req,
    input  req_eval_pkg::credit_arr_t credits,
    output logic                      out_valid,
    output req_eval_pkg::count_t      req_count,
    output logic                      req_single,
    output req_eval_pkg::index_t      min_port,
    output req_eval_pkg::credit_t     min_credit
);

    import req_eval_pkg::*;

    // counting branch results
    logic        cnt_valid;
    count_t      cnt;
    logic        cnt_single;

    // minimum branch results
    logic        min_valid;
    port_vec_t   min_onehot;
    credit_arr_t min_credits;

    // popcount of the requests
    req_count_stage req_count_stage_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .req        (req),
        .cnt_valid  (cnt_valid),
        .cnt        (cnt),
        .cnt_single (cnt_single)
    );

    // lowest credit among requesting ports
    min_search_stage min_search_stage_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_valid    (in_valid),
        .req         (req),
        .credits     (credits),
        .min_valid   (min_valid),
        .min_onehot  (min_onehot),
        .min_credits (min_credits)
    );

    // cnt_valid matches min_valid, only the latter strobes the combiner
    port_pick_stage port_pick_stage_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .min_valid   (min_valid),
        .min_onehot  (min_onehot),
        .min_credits (min_credits),
        .cnt         (cnt),
        .cnt_single  (cnt_single),
        .out_valid   (out_valid),
        .req_count   (req_count),
        .min_port    (min_port),
        .min_credit  (min_credit),
        .req_single  (req_single)
    );

endmodule

// ==== test/req_eval_props.sv ====
`timescale 1ns/1ps

module req_eval_props (
    input logic                 clk,
    input logic                 arst_n,
    input logic                 in_valid,
    input logic                 out_valid,
    input req_eval_pkg::count_t req_count,
    input logic                 req_single,
    input logic                 cnt_valid,
    input logic                 min_valid
);

    import req_eval_pkg::*;

    // two register stages between strobe and result
    a_latency: assert property (@(posedge clk) disable iff (!arst_n)
        out_valid == $past(in_valid, 2))
        else $error("out_valid does not follow in_valid by two cycles");

    // nothing comes out while reset is held
    a_reset_quiet: assert property (@(posedge clk)
        !arst_n |-> !out_valid)
        else $error("out_valid high during reset");

    // single flag only for zero or one request
    a_single_count: assert property (@(posedge clk) disable iff (!arst_n)
        (out_valid && req_single) |-> (req_count <= count_t'(1)))
        else $error("req_single set with more than one request");

    // both branches register on the same edge
    a_branch_sync: assert property (@(posedge clk) disable iff (!arst_n)
        cnt_valid == min_valid)
        else $error("cnt_valid and min_valid disagree");

endmodule

// internal branch valids reached through the bind scope
bind req_eval_top req_eval_props req_eval_props_i (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_valid   (in_valid),
    .out_valid  (out_valid),
    .req_count  (req_count),
    .req_single (req_single),
    .cnt_valid  (cnt_valid),
    .min_valid  (min_valid)
);

// ==== test/req_eval_tb.sv ====
`timescale 1ns/1ps
`include "req_eval_defines.svh"

module req_eval_tb;

    import req_eval_pkg::*;

    localparam int TEST_CYCLES    = 600;
    // reset, drain and margin on top of the test cycles
    localparam int TIMEOUT_CYCLES = TEST_CYCLES + 100;

    logic        clk;
    logic        arst_n;
    logic        in_valid;
    port_vec_t   req;
    credit_arr_t credits;
    logic        out_valid;
    count_t      req_count;
    logic        req_single;
    index_t      min_port;
    credit_t     min_credit;

    logic [31:0] rng_state;
    int          cycle_cnt;

    // expected results in strobe order
    count_t      exp_count_q[$];
    bit          exp_single_q[$];
    index_t      exp_port_q[$];
    credit_t     exp_credit_q[$];

    // last popped results, outputs hold these between strobes
    count_t      last_count;
    bit          last_single;
    index_t      last_port;
    credit_t     last_credit;

    // strobes driven one and two falling edges ago
    bit          strobe_d1;
    bit          strobe_d2;

    req_eval_top req_eval_top_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_valid   (in_valid),
        .req        (req),
        .credits    (credits),
        .out_valid  (out_valid),
        .req_count  (req_count),
        .req_single (req_single),
        .min_port   (min_port),
        .min_credit (min_credit)
    );

    always #4 clk = ~clk;

    // xorshift32 step
    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic abort_run(input string reason);
        $display("Test FAILED");
        $fatal(1, "%s", reason);
    endtask

    task automatic check_count(input string name, input count_t exp_v, input count_t act_v);
        if (act_v !== exp_v) begin
            $display("[FAIL] %s expected 0x%0h actual 0x%0h", name, exp_v, act_v);
            abort_run("value mismatch");
        end
    endtask

    task automatic check_index(input string name, input index_t exp_v, input index_t act_v);
        if (act_v !== exp_v) begin
            $display("[FAIL] %s expected 0x%0h actual 0x%0h", name, exp_v, act_v);
            abort_run("value mismatch");
        end
    endtask

    task automatic check_credit(input string name, input credit_t exp_v, input credit_t act_v);
        if (act_v !== exp_v) begin
            $display("[FAIL] %s expected 0x%0h actual 0x%0h", name, exp_v, act_v);
            abort_run("value mismatch");
        end
    endtask

    task automatic check_flag(input string name, input bit exp_v, input logic act_v);
        if (act_v !== exp_v) begin
            $display("[FAIL] %s expected 0x%0h actual 0x%0h", name, exp_v, act_v);
            abort_run("value mismatch");
        end
    endtask

    // reference model for one strobe
    task automatic push_expected(input port_vec_t r_vec, input credit_arr_t c_arr);
        count_t  n;
        index_t  idx;
        credit_t best;
        credit_t eff;
        n    = '0;
        idx  = '0;
        best = '1;
        for (int i = 0; i < `PORT_NUM; i++) begin
            if (r_vec[i]) n = n + count_t'(1);
            // idle port counts as all ones
            eff = r_vec[i] ? c_arr[i] : '1;
            // strict compare, so ties stay with the lower port
            if (eff < best) begin
                best = eff;
                idx  = index_t'(i);
            end
        end
        exp_count_q.push_back(n);
        exp_single_q.push_back(n <= count_t'(1));
        exp_port_q.push_back(idx);
        exp_credit_q.push_back(best);
    endtask

    // outputs are stable at the falling edge
    task automatic check_outputs();
        check_flag("out_valid", strobe_d2, out_valid);
        if (out_valid) begin
            if (exp_count_q.size() == 0) begin
                $display("ERROR: out_valid is high but no result was expected");
                abort_run("unexpected output");
            end
            last_count  = exp_count_q.pop_front();
            last_single = exp_single_q.pop_front();
            last_port   = exp_port_q.pop_front();
            last_credit = exp_credit_q.pop_front();
        end
        // new result or held result, same compare
        check_count("req_count", last_count, req_count);
        check_flag("req_single", last_single, req_single);
        check_index("min_port", last_port, min_port);
        check_credit("min_credit", last_credit, min_credit);
    endtask

    task automatic drive_cycle();
        logic [31:0] r;
        logic [31:0] mode;
        credit_t     base;
        port_vec_t   r_vec;
        credit_arr_t c_arr;
        r    = next_rand();
        mode = next_rand();
        base = r[20:16];
        // zero, single bit, all ones, or random requests
        case (r[2:0])
            3'd0:    r_vec = '0;
            3'd1:    r_vec = port_vec_t'(1) << r[5:3];
            3'd2:    r_vec = '1;
            default: r_vec = r[15:8];
        endcase
        for (int i = 0; i < `PORT_NUM; i++) begin
            r = next_rand();
            case (mode[1:0])
                // all equal, full tie
                2'd0:    c_arr[i] = base;
                // narrow range, frequent ties
                2'd1:    c_arr[i] = {3'b000, r[1:0]};
                default: c_arr[i] = r[4:0];
            endcase
        end
        strobe_d2 = strobe_d1;
        strobe_d1 = mode[8];
        in_valid  = mode[8];
        req       = r_vec;
        credits   = c_arr;
        if (mode[8]) push_expected(r_vec, c_arr);
    endtask

    task automatic drive_idle();
        strobe_d2 = strobe_d1;
        strobe_d1 = 1'b0;
        in_valid  = 1'b0;
    endtask

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run("timeout");
        end
    end

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        in_valid    = 1'b0;
        req         = '0;
        credits     = '0;
        rng_state   = 32'd8;
        cycle_cnt   = 0;
        strobe_d1   = 1'b0;
        strobe_d2   = 1'b0;
        // registers clear to zero in reset
        last_count  = '0;
        last_single = 1'b0;
        last_port   = '0;
        last_credit = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        for (int n = 0; n < TEST_CYCLES; n++) begin
            @(negedge clk);
            check_outputs();
            drive_cycle();
        end
        // two stage pipeline, a few idle cycles drain it
        repeat (4) begin
            @(negedge clk);
            check_outputs();
            drive_idle();
        end
        if (exp_count_q.size() != 0) begin
            $display("ERROR: %0d strobes never produced a result", exp_count_q.size());
            abort_run("missing output");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule

// ==== tb.f ====
+incdir+rtl
rtl/req_eval_pkg.sv
rtl/carry_sum_cell.sv
rtl/par_count_7.sv
rtl/par_count_15.sv
rtl/req_count_stage.sv
rtl/min_search_stage.sv
rtl/one_hot_mux.sv
rtl/port_pick_stage.sv
rtl/req_eval_top.sv
test/req_eval_props.sv
test/req_eval_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, and pass only if the pass message shows up
verilator --binary --timing --assert -f tb.f --top-module req_eval_tb -o req_eval_sim \
    && ./obj_dir/req_eval_sim | tee /dev/stderr | grep -q "Test OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
